/* verilog.f */
+incdir+hdl
hdl/ooo_pkg.sv
hdl/dispatch_unit.sv
hdl/phys_regfile.sv
hdl/alu_station.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
testbench/tb_ooo_core.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ooo_pkg.sv
      - hdl/dispatch_unit.sv
      - hdl/phys_regfile.sv
      - hdl/alu_station.sv
      - hdl/reorder_buffer.sv
      - hdl/ooo_core.sv
  - target: test
    files:
      - testbench/tb_ooo_core.sv

/* testbench/tb_ooo_core.sv */
`default_nettype none

module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEND_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT = 400;

    logic clk;
    logic rst_n;
    logic insn_valid;
    ooo_pkg::insn_t insn;
    logic insn_ready;
    ooo_pkg::commit_t commit;

    ooo_pkg::xdata_t model_regs [32];
    ooo_pkg::commit_t expected_q [$]; // program order
    int value_errors;
    int other_errors;

    ooo_core i_ooo_core (.clk, .rst_n, .insn_valid, .insn, .insn_ready, .commit);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic ooo_pkg::insn_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                              input logic [4:0] rd, rs1, rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic ooo_pkg::insn_t i_type(input logic [11:0] imm, input logic [2:0] funct3,
                                              input logic [4:0] rd, rs1);
        return {imm, rs1, funct3, rd, 7'b0010011};
    endfunction

    // RV32I semantics of OP and OP-IMM
    function automatic ooo_pkg::xdata_t model_result(input ooo_pkg::insn_t w);
        ooo_pkg::xdata_t a;
        ooo_pkg::xdata_t b;
        ooo_pkg::xdata_t res;
        logic is_imm;
        is_imm = w[6:0] == 7'b0010011;
        a = model_regs[w[19:15]];
        b = is_imm ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        case (w[14:12])
            3'b000: res = (!is_imm && w[30]) ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = {31'd0, $signed(a) < $signed(b)};
            3'b011: res = {31'd0, a < b};
            3'b100: res = a ^ b;
            3'b101: begin
                if (w[30]) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic void record_accept(input ooo_pkg::insn_t w);
        ooo_pkg::commit_t c;
        c.valid = 1'b1;
        c.rd = w[11:7];
        c.value = (c.rd == 5'd0) ? '0 : model_result(w);
        if (c.rd != 5'd0) model_regs[c.rd] = c.value;
        expected_q.push_back(c);
    endfunction

    task automatic send_insn(input ooo_pkg::insn_t w);
        int waited;
        waited = 0;
        @(negedge clk);
        insn_valid = 1'b1;
        insn = w;
        @(posedge clk);
        while (!insn_ready && waited < SEND_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        assert (insn_ready) record_accept(w);
        else begin
            other_errors++;
            $display("instruction %h was not accepted within %0d cycles", w, SEND_TIMEOUT);
            @(negedge clk);
            insn_valid = 1'b0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            insn_valid = 1'b0;
        end
    endtask

    task automatic drain_commits();
        int waited;
        waited = 0;
        @(negedge clk);
        insn_valid = 1'b0;
        while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        assert (expected_q.size() == 0)
        else begin
            other_errors++;
            $display("%0d commits still missing after %0d cycles", expected_q.size(),
                     DRAIN_TIMEOUT);
            expected_q.delete();
        end
    endtask

    // every commit against the oldest outstanding instruction
    always @(posedge clk) begin : commit_monitor
        ooo_pkg::commit_t expected;
        if (rst_n && commit.valid) begin
            assert (expected_q.size() != 0)
            else begin
                other_errors++;
                $display("commit to x%0d at %0t with no instruction outstanding", commit.rd,
                         $time);
            end
            if (expected_q.size() != 0) begin
                expected = expected_q.pop_front();
                assert (commit.rd == expected.rd && commit.value == expected.value)
                else begin
                    value_errors++;
                    $display("Fail at %0t: commit x%0d = %h, expected x%0d = %h", $time,
                             commit.rd, commit.value, expected.rd, expected.value);
                end
            end
        end
    end

    task automatic check_reset_state();
        @(negedge clk);
        assert (!commit.valid)
        else begin
            other_errors++;
            $display("commit valid is high right after reset");
        end
        assert (insn_ready)
        else begin
            other_errors++;
            $display("insn_ready is low right after reset");
        end
    endtask

    task automatic independent_ops();
        send_insn(i_type(12'h123, 3'b000, 5'd1, 5'd0));
        send_insn(i_type(12'hffb, 3'b000, 5'd2, 5'd0)); // -5
        send_insn(i_type(12'd3, 3'b000, 5'd3, 5'd0));
        send_insn(r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
        send_insn(r_type(7'h20, 3'b000, 5'd5, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b001, 5'd6, 5'd1, 5'd3));
        send_insn(r_type(7'h00, 3'b010, 5'd7, 5'd2, 5'd1));
        send_insn(r_type(7'h00, 3'b011, 5'd8, 5'd2, 5'd1));
        send_insn(r_type(7'h00, 3'b100, 5'd9, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b101, 5'd10, 5'd2, 5'd3));
        send_insn(r_type(7'h20, 3'b101, 5'd11, 5'd2, 5'd3));
        send_insn(r_type(7'h00, 3'b110, 5'd12, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b111, 5'd13, 5'd1, 5'd2));
        send_insn(i_type(12'hfff, 3'b010, 5'd14, 5'd2));
        send_insn(i_type(12'h7ff, 3'b011, 5'd15, 5'd1));
        send_insn(i_type(12'hfff, 3'b100, 5'd16, 5'd1));
        send_insn(i_type({7'h20, 5'd1}, 3'b101, 5'd17, 5'd2)); // srai
        send_insn(i_type({7'h00, 5'd28}, 3'b101, 5'd18, 5'd2));
        send_insn(i_type({7'h00, 5'd4}, 3'b001, 5'd19, 5'd1));
        send_insn(i_type(12'h100, 3'b110, 5'd20, 5'd2));
        send_insn(i_type(12'h0f0, 3'b111, 5'd21, 5'd1));
        drain_commits();
    endtask

    task automatic dependency_chain();
        send_insn(i_type(12'd3, 3'b000, 5'd5, 5'd0));
        send_insn(r_type(7'h00, 3'b000, 5'd6, 5'd5, 5'd5));
        send_insn(i_type(12'h0ff, 3'b100, 5'd7, 5'd6));
        send_insn(r_type(7'h20, 3'b000, 5'd8, 5'd7, 5'd6));
        send_insn(r_type(7'h00, 3'b001, 5'd9, 5'd8, 5'd5));
        send_insn(i_type({7'h20, 5'd2}, 3'b101, 5'd10, 5'd9));
        send_insn(r_type(7'h00, 3'b111, 5'd11, 5'd10, 5'd7));
        send_insn(r_type(7'h00, 3'b011, 5'd12, 5'd11, 5'd10));
        drain_commits();
    endtask

    task automatic rename_hazards();
        send_insn(i_type(12'd7, 3'b000, 5'd10, 5'd0));
        send_insn(r_type(7'h00, 3'b000, 5'd11, 5'd10, 5'd10));
        send_insn(i_type(12'd9, 3'b000, 5'd10, 5'd0)); // waw and war on x10
        send_insn(r_type(7'h20, 3'b000, 5'd12, 5'd11, 5'd10));
        send_insn(i_type(12'd1, 3'b000, 5'd10, 5'd10));
        send_insn(r_type(7'h00, 3'b000, 5'd10, 5'd10, 5'd12));
        send_insn(r_type(7'h00, 3'b110, 5'd11, 5'd10, 5'd11));
        send_insn(i_type(12'hfff, 3'b000, 5'd10, 5'd0));
        send_insn(r_type(7'h20, 3'b101, 5'd13, 5'd10, 5'd11));
        drain_commits();
    endtask

    task automatic x0_writes();
        send_insn(i_type(12'd55, 3'b000, 5'd0, 5'd0));
        send_insn(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
        send_insn(i_type(12'd0, 3'b000, 5'd3, 5'd0));
        send_insn(r_type(7'h00, 3'b110, 5'd4, 5'd0, 5'd0));
        send_insn(r_type(7'h00, 3'b000, 5'd5, 5'd0, 5'd1));
        drain_commits();
    endtask

    task automatic random_stream();
        logic [2:0] f3;
        logic [4:0] rd, rs1, rs2;
        logic [6:0] f7;
        logic [11:0] imm;
        for (int n = 0; n < 100; n++) begin
            f3 = 3'($urandom_range(0, 7));
            rd = 5'($urandom_range(0, 15));
            rs1 = 5'($urandom_range(0, 15));
            rs2 = 5'($urandom_range(0, 15));
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
            imm = 12'($urandom);
            if (f3 == 3'b001) imm = {7'h00, imm[4:0]};
            else if (f3 == 3'b101) imm = {f7, imm[4:0]};
            if ($urandom_range(0, 1)) send_insn(r_type(f7, f3, rd, rs1, rs2));
            else send_insn(i_type(imm, f3, rd, rs1));
            idle_cycles($urandom_range(0, 3));
        end
        drain_commits();
    endtask

    initial begin
        void'($urandom(32'hb048_3314));
        value_errors = 0;
        other_errors = 0;
        foreach (model_regs[i]) model_regs[i] = '0;
        rst_n = 1'b0;
        insn_valid = 1'b0;
        insn = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        independent_ops();
        dependency_chain();
        rename_hazards();
        x0_writes();
        random_stream();
        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/ooo_core.sv */
`default_nettype none
`include "ooo_defs.svh"

module ooo_core (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            insn_valid,
    input  wire ooo_pkg::insn_t  insn,
    output logic                 insn_ready,
    output ooo_pkg::commit_t     commit
);

    ooo_pkg::preg_t src1_tag, src2_tag;
    ooo_pkg::xdata_t src1_value, src2_value;
    logic src1_ready, src2_ready;
    logic rs_full, rob_full, dispatch_valid;
    ooo_pkg::rob_tag_t rob_tail;
    ooo_pkg::rs_entry_t rs_entry;
    ooo_pkg::rob_entry_t rob_entry;
    ooo_pkg::wb_bus_t wb;     // single result broadcast
    ooo_pkg::free_t free;

    dispatch_unit i_dispatch_unit (
        .clk, .rst_n,
        .insn_valid, .insn, .insn_ready,
        .src1_tag, .src2_tag,
        .src1_value, .src2_value, .src1_ready, .src2_ready,
        .wb, .rs_full, .rob_full, .rob_tail,
        .dispatch_valid, .rs_entry, .rob_entry,
        .free
    );

    phys_regfile i_phys_regfile (
        .clk, .rst_n,
        .src1_tag, .src2_tag,
        .src1_value, .src2_value, .src1_ready, .src2_ready,
        .wb, .dispatch_valid,
        .alloc_tag (rs_entry.dst)
    );

    alu_station i_alu_station (
        .clk, .rst_n,
        .dispatch_valid, .rs_entry,
        .rs_full, .wb
    );

    reorder_buffer i_reorder_buffer (
        .clk, .rst_n,
        .dispatch_valid, .rob_entry,
        .rob_tail, .rob_full,
        .wb, .commit, .free
    );

endmodule

`default_nettype wire

/* hdl/reorder_buffer.sv */
`default_nettype none
`include "ooo_defs.svh"

module reorder_buffer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 dispatch_valid,
    input  wire ooo_pkg::rob_entry_t  rob_entry,
    output ooo_pkg::rob_tag_t         rob_tail,
    output logic                      rob_full,
    input  wire ooo_pkg::wb_bus_t     wb,
    output ooo_pkg::commit_t          commit,
    output ooo_pkg::free_t            free
);

    localparam int CNT_W = $clog2(`OOO_ROB_DEPTH) + 1;
    localparam logic [CNT_W-1:0] ROB_FULL = CNT_W'(`OOO_ROB_DEPTH);

    ooo_pkg::rob_entry_t entries [`OOO_ROB_DEPTH];
    ooo_pkg::xdata_t values [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_DEPTH-1:0] done;

    ooo_pkg::rob_tag_t head;
    ooo_pkg::rob_tag_t tail;
    logic [CNT_W-1:0] count;

    logic head_fire;
    ooo_pkg::rob_entry_t head_entry;
    ooo_pkg::rob_tag_t wb_offset;

    assign rob_tail = tail;
    assign rob_full = count == ROB_FULL;

    assign head_entry = entries[head];
    assign head_fire = (count != '0) && done[head];

    always_comb begin
        commit.valid = head_fire;
        commit.rd = head_entry.rd;
        commit.value = (head_entry.rd == '0) ? '0 : values[head]; // x0 reads back zero
        free.valid = head_fire && (head_entry.rd != '0);
        free.preg = head_entry.old_preg;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            done <= '0;
        end else begin
            if (dispatch_valid) begin
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (wb.valid) done[wb.rob_tag] <= 1'b1;
            if (head_fire) head <= head + 1'b1;
            case ({dispatch_valid, head_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) entries[tail] <= rob_entry;
        if (wb.valid) values[wb.rob_tag] <= wb.value;
    end

    // distance from head, wraps with the tag width
    assign wb_offset = wb.rob_tag - head;

    a_wb_live_entry: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> {1'b0, wb_offset} < count);

endmodule

`default_nettype wire

/* hdl/alu_station.sv */
`default_nettype none
`include "ooo_defs.svh"

module alu_station (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                dispatch_valid,
    input  wire ooo_pkg::rs_entry_t  rs_entry,
    output logic                     rs_full,
    output ooo_pkg::wb_bus_t         wb
);

    localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

    ooo_pkg::rs_entry_t slots [`OOO_RS_DEPTH];
    logic [`OOO_RS_DEPTH-1:0] valid;

    logic [IDX_W-1:0] fill_idx;
    logic [IDX_W-1:0] issue_idx;
    logic issue_en;
    ooo_pkg::rs_entry_t issue_entry;

    // registered ALU stage
    logic wb_valid_q;
    ooo_pkg::preg_t wb_dst_q;
    ooo_pkg::rob_tag_t wb_tag_q;
    ooo_pkg::xdata_t wb_value_q;

    assign rs_full = &valid;

    // walk down so the lowest index wins
    always_comb begin
        fill_idx = '0;
        issue_idx = '0;
        issue_en = 1'b0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) fill_idx = IDX_W'(i);
            if (valid[i] && slots[i].src1_ready && slots[i].src2_ready) begin
                issue_idx = IDX_W'(i);
                issue_en = 1'b1;
            end
        end
    end

    assign issue_entry = slots[issue_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            wb_valid_q <= 1'b0;
        end else begin
            if (issue_en) valid[issue_idx] <= 1'b0;
            if (dispatch_valid) valid[fill_idx] <= 1'b1;
            wb_valid_q <= issue_en;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (wb.valid && valid[i]) begin
                if (!slots[i].src1_ready && slots[i].src1_tag == wb.dst) begin
                    slots[i].src1_ready <= 1'b1;
                    slots[i].src1_value <= wb.value;
                end
                if (!slots[i].imm_sel && !slots[i].src2_ready &&
                    slots[i].src2_tag == wb.dst) begin
                    slots[i].src2_ready <= 1'b1;
                    slots[i].src2_value <= wb.value;
                end
            end
        end
        if (dispatch_valid) slots[fill_idx] <= rs_entry;
        if (issue_en) begin
            wb_dst_q <= issue_entry.dst;
            wb_tag_q <= issue_entry.rob_tag;
            wb_value_q <= ooo_pkg::alu_compute(issue_entry.op, issue_entry.src1_value,
                                               issue_entry.src2_value);
        end
    end

    assign wb = '{valid: wb_valid_q, dst: wb_dst_q, rob_tag: wb_tag_q, value: wb_value_q};

    // dispatch must see rs_full before pushing
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_valid |-> !rs_full);

endmodule

`default_nettype wire

/* hdl/phys_regfile.sv */
`default_nettype none
`include "ooo_defs.svh"

module phys_regfile (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire ooo_pkg::preg_t    src1_tag,
    input  wire ooo_pkg::preg_t    src2_tag,
    output ooo_pkg::xdata_t        src1_value,
    output ooo_pkg::xdata_t        src2_value,
    output logic                   src1_ready,
    output logic                   src2_ready,
    input  wire ooo_pkg::wb_bus_t  wb,
    input  wire logic              dispatch_valid,
    input  wire ooo_pkg::preg_t    alloc_tag
);

    ooo_pkg::xdata_t regs [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] ready;

    logic do_alloc, do_write;

    // physical register 0 backs x0 and is never touched
    assign do_alloc = dispatch_valid && (alloc_tag != '0);
    assign do_write = wb.valid && (wb.dst != '0);

    // dispatch read ports
    assign src1_value = regs[src1_tag];
    assign src2_value = regs[src2_tag];
    assign src1_ready = ready[src1_tag];
    assign src2_ready = ready[src2_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                regs[i] <= '0;
                ready[i] <= (i < `OOO_ARCH_REGS); // mapped regs start valid
            end
        end else begin
            if (do_alloc) begin
                ready[alloc_tag] <= 1'b0;
            end
            if (do_write) begin
                regs[wb.dst] <= wb.value;
                ready[wb.dst] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dispatch_unit.sv */
`default_nettype none
`include "ooo_defs.svh"

module dispatch_unit (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   insn_valid,
    input  wire ooo_pkg::insn_t         insn,
    output logic                        insn_ready,
    output ooo_pkg::preg_t              src1_tag,
    output ooo_pkg::preg_t              src2_tag,
    input  wire ooo_pkg::xdata_t        src1_value,
    input  wire ooo_pkg::xdata_t        src2_value,
    input  wire logic                   src1_ready,
    input  wire logic                   src2_ready,
    input  wire ooo_pkg::wb_bus_t       wb,
    input  wire logic                   rs_full,
    input  wire logic                   rob_full,
    input  wire ooo_pkg::rob_tag_t      rob_tail,
    output logic                        dispatch_valid,
    output ooo_pkg::rs_entry_t          rs_entry,
    output ooo_pkg::rob_entry_t         rob_entry,
    input  wire ooo_pkg::free_t         free
);

    localparam int FREE_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int FREE_W = $clog2(FREE_DEPTH);
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    ooo_pkg::preg_t rat [`OOO_ARCH_REGS];
    ooo_pkg::preg_t free_list [FREE_DEPTH];
    logic [FREE_W-1:0] fl_head;
    logic [FREE_W-1:0] fl_tail;
    logic [FREE_W:0] fl_count;

    ooo_pkg::areg_t rd, rs1, rs2;
    logic [2:0] funct3;
    logic alt; // funct7[5], picks SUB / SRA
    logic is_op, imm_sel, alloc, bypass1, bypass2;
    ooo_pkg::xdata_t imm;
    ooo_pkg::alu_op_e op;
    ooo_pkg::preg_t new_tag;

    assign rd = insn[11:7];
    assign rs1 = insn[19:15];
    assign rs2 = insn[24:20];
    assign funct3 = insn[14:12];
    assign alt = insn[30];
    assign is_op = insn[6:0] == OPC_OP;
    assign imm_sel = insn[6:0] == OPC_OP_IMM;
    assign imm = {{(`OOO_XLEN-12){insn[31]}}, insn[31:20]};

    always_comb begin
        case (funct3)
            3'b000: op = (is_op && alt) ? ooo_pkg::ALU_SUB : ooo_pkg::ALU_ADD;
            3'b001: op = ooo_pkg::ALU_SLL;
            3'b010: op = ooo_pkg::ALU_SLT;
            3'b011: op = ooo_pkg::ALU_SLTU;
            3'b100: op = ooo_pkg::ALU_XOR;
            3'b101: op = alt ? ooo_pkg::ALU_SRA : ooo_pkg::ALU_SRL;
            3'b110: op = ooo_pkg::ALU_OR;
            default: op = ooo_pkg::ALU_AND;
        endcase
    end

    assign insn_ready = (fl_count != '0) && !rs_full && !rob_full;
    assign dispatch_valid = insn_valid && insn_ready;
    assign alloc = dispatch_valid && (rd != '0); // x0 takes no register
    assign new_tag = free_list[fl_head];

    assign src1_tag = rat[rs1];
    assign src2_tag = rat[rs2];

    // result broadcast this cycle is not in the regfile yet
    assign bypass1 = wb.valid && (wb.dst != '0) && (wb.dst == src1_tag);
    assign bypass2 = wb.valid && (wb.dst != '0) && (wb.dst == src2_tag);

    always_comb begin
        rs_entry.op = op;
        rs_entry.dst = (rd != '0) ? new_tag : '0;
        rs_entry.rob_tag = rob_tail;
        rs_entry.src1_ready = src1_ready || bypass1;
        rs_entry.src1_tag = src1_tag;
        rs_entry.src1_value = bypass1 ? wb.value : src1_value;
        rs_entry.src2_ready = imm_sel || src2_ready || bypass2;
        rs_entry.src2_tag = imm_sel ? '0 : src2_tag;
        rs_entry.src2_value = imm_sel ? imm : (bypass2 ? wb.value : src2_value);
        rs_entry.imm_sel = imm_sel;
        rob_entry.rd = rd;
        rob_entry.old_preg = rat[rd];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) rat[i] <= ooo_pkg::preg_t'(i);
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= ooo_pkg::preg_t'(`OOO_ARCH_REGS + i);
            end
            fl_head <= '0;
            fl_tail <= '0; // list starts full, tail wrapped
            fl_count <= (FREE_W + 1)'(FREE_DEPTH);
        end else begin
            if (alloc) begin
                rat[rd] <= new_tag;
                fl_head <= fl_head + 1'b1;
            end
            if (free.valid) begin
                free_list[fl_tail] <= free.preg;
                fl_tail <= fl_tail + 1'b1;
            end
            case ({alloc, free.valid})
                2'b10: fl_count <= fl_count - 1'b1;
                2'b01: fl_count <= fl_count + 1'b1;
                default: ;
            endcase
        end
    end

    // a full list means nothing is in flight, so nothing can come back
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        free.valid |-> fl_count < (FREE_W + 1)'(FREE_DEPTH));

endmodule

`default_nettype wire

/* hdl/ooo_pkg.sv */
`default_nettype none
`include "ooo_defs.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0] xdata_t;
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] areg_t;
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] preg_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [31:0] insn_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef struct packed {
        alu_op_e  op;
        preg_t    dst;
        rob_tag_t rob_tag;
        logic     src1_ready;
        preg_t    src1_tag;
        xdata_t   src1_value;
        logic     src2_ready;
        preg_t    src2_tag;
        xdata_t   src2_value; // holds the immediate when imm_sel is set
        logic     imm_sel;
    } rs_entry_t;

    typedef struct packed {
        areg_t rd;
        preg_t old_preg;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        preg_t    dst;
        rob_tag_t rob_tag;
        xdata_t   value;
    } wb_bus_t;

    typedef struct packed {
        logic   valid;
        areg_t  rd;
        xdata_t value;
    } commit_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } free_t;

    function automatic xdata_t alu_compute(input alu_op_e op, input xdata_t a, input xdata_t b);
        logic [$clog2(`OOO_XLEN)-1:0] shamt;
        xdata_t res;
        shamt = b[$clog2(`OOO_XLEN)-1:0];
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_SLL:  res = a << shamt;
            ALU_SLT:  res = xdata_t'($signed(a) < $signed(b));
            ALU_SLTU: res = xdata_t'(a < b);
            ALU_XOR:  res = a ^ b;
            ALU_SRL:  res = a >> shamt;
            ALU_SRA:  res = xdata_t'($signed(a) >>> shamt);
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            default:  res = '0;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

/* hdl/ooo_defs.svh */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// data path width
`define OOO_XLEN 32

// architectural register count, x0 included
`define OOO_ARCH_REGS 32

// physical register count
`define OOO_PHYS_REGS 64

// ALU reservation station entries
`define OOO_RS_DEPTH 4

// reorder buffer entries, also the in-flight limit
`define OOO_ROB_DEPTH 8

`endif
